//--- compile.f
src/rename_pkg.sv
src/branch_pkg.sv
src/psel_gen.sv
src/free_list.sv
src/map_table.sv
src/br_stack.sv
src/rename_ctrl.sv
src/rename_unit.sv
dv/clock_gen.sv
dv/rename_unit_tb.sv

//--- Makefile
TOP := rename_unit_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f compile.f -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

//--- dv/rename_unit_tb.sv
module rename_unit_tb import rename_pkg::*, branch_pkg::*; ();

    localparam int depth   = BR_DEPTH;
    localparam int period  = 40;
    localparam int FL_SIZE = PHYS_REGS - ARCH_REGS;

    typedef logic [depth-1:0] bid_t;

    // one cycle of stimulus followed by what the DUT should answer
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic        has_dest;
        arch_idx_t   dest;
        arch_idx_t   src;
        logic        is_branch;
        logic        cdb_v;
        phys_tag_t   cdb_tag;
        logic        ret_v;
        phys_tag_t   ret_tag;
        br_task_t    op;
        bid_t        rem;
        logic        e_ready;
        phys_tag_t   e_new;
        phys_tag_t   e_old;
        phys_tag_t   e_src_tag;
        logic        e_src_rdy;
        bid_t        e_bid;
        logic        e_rec;
        logic [31:0] e_rec_pc;
    } row_t;

    logic        clock;
    logic        reset;
    logic        dispatch_valid;
    logic [31:0] dispatch_pc;
    logic        has_dest;
    arch_idx_t   dest_arch;
    arch_idx_t   src_arch;
    logic        is_branch;
    logic        dispatch_ready;
    phys_tag_t   src_tag;
    logic        src_ready;
    phys_tag_t   new_tag;
    phys_tag_t   old_tag;
    bid_t        assigned_b_id;
    logic        cdb_valid;
    phys_tag_t   cdb_tag;
    logic        retire_valid;
    phys_tag_t   retire_tag;
    br_task_t    br_task;
    bid_t        rem_b_id;
    logic        recover_valid;
    logic [31:0] recover_pc;

    row_t rows[$];
    phys_tag_t freed[$];
    int row_idx = 0;
    int cycles = 0;
    int limit = 0;

    // reference model state
    phys_tag_t   mt_tag [ARCH_REGS];
    logic        mt_rdy [ARCH_REGS];
    phys_tag_t   fl [FL_SIZE];
    int          fl_head;
    int          fl_tail;
    logic        cp_valid [depth];
    bid_t        cp_mask [depth];
    logic [31:0] cp_pc [depth];
    int          cp_head [depth];
    phys_tag_t   cp_tag [depth][ARCH_REGS];
    logic        cp_rdy [depth][ARCH_REGS];
    logic        in_recover;
    phys_tag_t   rec_tag [ARCH_REGS];
    logic        rec_rdy [ARCH_REGS];
    int          rec_head;
    logic [31:0] rec_pc;
    arch_idx_t   last_dest;
    phys_tag_t   last_new;

    clock_gen #(
        .period(period)
    ) u_clock (
        .clock(clock)
    );

    rename_unit #(
        .depth(depth)
    ) uut (
        .clock         (clock),
        .reset         (reset),
        .dispatch_valid(dispatch_valid),
        .dispatch_pc   (dispatch_pc),
        .has_dest      (has_dest),
        .dest_arch     (dest_arch),
        .src_arch      (src_arch),
        .is_branch     (is_branch),
        .dispatch_ready(dispatch_ready),
        .src_tag       (src_tag),
        .src_ready     (src_ready),
        .new_tag       (new_tag),
        .old_tag       (old_tag),
        .assigned_b_id (assigned_b_id),
        .cdb_valid     (cdb_valid),
        .cdb_tag       (cdb_tag),
        .retire_valid  (retire_valid),
        .retire_tag    (retire_tag),
        .br_task       (br_task),
        .rem_b_id      (rem_b_id),
        .recover_valid (recover_valid),
        .recover_pc    (recover_pc)
    );

    task automatic abort_run();
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic check_tag(input string name, input phys_tag_t got, input phys_tag_t exp);
        if (got !== exp) begin
            $display("FAIL row %0d %s got %h expected %h", row_idx, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_bid(input string name, input bid_t got, input bid_t exp);
        if (got !== exp) begin
            $display("FAIL row %0d %s got %h expected %h", row_idx, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL row %0d %s got %h expected %h", row_idx, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_pc(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL row %0d %s got %h expected %h", row_idx, name, got, exp);
            abort_run();
        end
    endtask

    task automatic model_reset();
        for (int a = 0; a < ARCH_REGS; a++) begin
            mt_tag[a] = phys_tag_t'(a);
            mt_rdy[a] = 1'b1;
        end
        for (int i = 0; i < FL_SIZE; i++) begin
            fl[i] = phys_tag_t'(ARCH_REGS + i);
        end
        fl_head = 0;
        fl_tail = FL_SIZE;
        for (int i = 0; i < depth; i++) begin
            cp_valid[i] = 1'b0;
            cp_mask[i]  = '0;
        end
        in_recover = 1'b0;
        rec_pc     = '0;
    endtask

    // advance the model by one cycle and record the row with its expectations
    task automatic model_row(input row_t stim);
        row_t r;
        bid_t live;
        logic accept;
        logic alloc;
        logic take;
        int   slot;
        int   sq;
        r    = stim;
        slot = -1;
        sq   = -1;
        for (int i = depth - 1; i >= 0; i--) begin
            live[i] = cp_valid[i];
            if (!cp_valid[i]) begin
                slot = i;
            end
        end
        r.e_ready   = !in_recover && r.op == NONE && !(&live && r.is_branch)
                    && !(fl_tail == fl_head && r.has_dest);
        r.e_new     = fl[fl_head % FL_SIZE];
        r.e_old     = mt_tag[r.dest];
        r.e_src_tag = mt_tag[r.src];
        r.e_src_rdy = mt_rdy[r.src];
        accept      = r.valid && r.e_ready;
        alloc       = accept && r.has_dest;
        take        = accept && r.is_branch;
        r.e_bid     = take ? bid_t'(1) << slot : '0;
        r.e_rec     = in_recover;
        r.e_rec_pc  = rec_pc;

        // map and free list
        if (in_recover) begin
            mt_tag  = rec_tag;
            mt_rdy  = rec_rdy;
            fl_head = rec_head;
        end else if (alloc) begin
            mt_tag[r.dest] = r.e_new;
            mt_rdy[r.dest] = 1'b0;
            last_dest      = r.dest;
            last_new       = r.e_new;
            fl_head++;
            freed.push_back(r.e_old);
        end
        if (r.ret_v) begin
            fl[fl_tail % FL_SIZE] = r.ret_tag;
            fl_tail++;
        end

        // branch stack
        for (int i = 0; i < depth; i++) begin
            if (r.op == SQUASH) begin
                if (cp_valid[i] && (bid_t'(1) << i) == r.rem) begin
                    sq = i;
                    cp_valid[i] = 1'b0;
                end
                if ((cp_mask[i] & r.rem) != '0) begin
                    cp_valid[i] = 1'b0;
                end
            end else if (r.op == CLEAR) begin
                if ((bid_t'(1) << i) == r.rem) begin
                    cp_valid[i] = 1'b0;
                end
                cp_mask[i] = cp_mask[i] & ~r.rem;
            end else if (take && i == slot) begin
                cp_valid[i] = 1'b1;
                cp_mask[i]  = live;
                cp_pc[i]    = r.pc;
                cp_head[i]  = fl_head;
                cp_tag[i]   = mt_tag;
                cp_rdy[i]   = mt_rdy;
            end
        end

        // completion broadcast reaches the live map and every checkpoint
        for (int a = 0; a < ARCH_REGS; a++) begin
            if (r.cdb_v && mt_tag[a] == r.cdb_tag) begin
                mt_rdy[a] = 1'b1;
            end
            for (int i = 0; i < depth; i++) begin
                if (r.cdb_v && cp_tag[i][a] == r.cdb_tag) begin
                    cp_rdy[i][a] = 1'b1;
                end
            end
        end

        if (r.op == SQUASH && sq >= 0) begin
            rec_tag  = cp_tag[sq];
            rec_rdy  = cp_rdy[sq];
            rec_head = cp_head[sq];
            rec_pc   = cp_pc[sq];
        end
        in_recover = (r.op == SQUASH);
        rows.push_back(r);
    endtask

    function automatic row_t blank_row();
        row_t r;
        r      = '0;
        r.dest = arch_idx_t'($urandom);
        r.src  = arch_idx_t'($urandom);
        r.pc   = $urandom;
        r.op   = NONE;
        return r;
    endfunction

    task automatic add_rename(input logic dest_on, input logic branch_on);
        row_t r;
        r           = blank_row();
        r.valid     = 1'b1;
        r.has_dest  = dest_on;
        r.is_branch = branch_on;
        model_row(r);
    endtask

    task automatic build_table();
        row_t      r;
        arch_idx_t dep;
        phys_tag_t dep_tag;
        // tags come out of the free list from 32 upward
        repeat (6) add_rename(1'b1, 1'b0);
        dep     = last_dest;
        dep_tag = last_new;
        r       = blank_row();
        r.valid = 1'b1;
        r.src   = dep;
        model_row(r);
        r         = blank_row();
        r.cdb_v   = 1'b1;
        r.cdb_tag = dep_tag;
        model_row(r);
        r       = blank_row();
        r.valid = 1'b1;
        r.src   = dep;
        model_row(r);
        // fill every slot so the extra branch stalls
        repeat (2) add_rename(1'b1, 1'b1);
        add_rename(1'b1, 1'b1);
        // the third branch keeps its own pending mapping in its checkpoint
        dep     = last_dest;
        dep_tag = last_new;
        repeat (depth - 2) add_rename(1'b1, 1'b1);
        r     = blank_row();
        r.op  = CLEAR;
        r.rem = bid_t'(2);
        model_row(r);
        // freed id comes back and the stack fills again
        repeat (2) add_rename(1'b1, 1'b1);
        repeat (3) add_rename(1'b1, 1'b0);
        r         = blank_row();
        r.op      = SQUASH;
        r.rem     = bid_t'(4);
        r.cdb_v   = 1'b1;
        r.cdb_tag = dep_tag;
        model_row(r);
        // nothing is dispatched in the recovery cycle
        r = blank_row();
        model_row(r);
        // the restored map carries the broadcast of the squash cycle
        r          = blank_row();
        r.valid    = 1'b1;
        r.has_dest = 1'b1;
        r.src      = dep;
        model_row(r);
        repeat (3) add_rename(1'b1, 1'b0);
        add_rename(1'b1, 1'b1);
        // retire the replaced tags until the list wraps
        freed.delete();
        for (int i = 0; i < 45; i++) begin
            r          = blank_row();
            r.valid    = 1'b1;
            r.has_dest = 1'b1;
            if (freed.size() > 0) begin
                r.ret_v   = 1'b1;
                r.ret_tag = freed.pop_front();
            end
            if (i % 3 == 0) begin
                r.cdb_v   = 1'b1;
                r.cdb_tag = last_new;
            end
            model_row(r);
        end
    endtask

    task automatic drive(input row_t r);
        dispatch_valid = r.valid;
        dispatch_pc    = r.pc;
        has_dest       = r.has_dest;
        dest_arch      = r.dest;
        src_arch       = r.src;
        is_branch      = r.is_branch;
        cdb_valid      = r.cdb_v;
        cdb_tag        = r.cdb_tag;
        retire_valid   = r.ret_v;
        retire_tag     = r.ret_tag;
        br_task        = r.op;
        rem_b_id       = r.rem;
    endtask

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("timeout: the stimulus table did not finish within %0d cycles", limit);
            abort_run();
        end
    end

    initial begin
        row_t cur;
        void'($urandom(32'hfe18c872));
        reset = 1'b1;
        cur   = '0;
        cur.op = NONE;
        drive(cur);
        model_reset();
        build_table();
        limit = rows.size() + 20;

        repeat (4) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        for (row_idx = 0; row_idx < rows.size(); row_idx++) begin
            cur = rows[row_idx];
            drive(cur);
            #(period / 4);
            check_bit("dispatch_ready", dispatch_ready, cur.e_ready);
            if (cur.valid) begin
                check_tag("src_tag", src_tag, cur.e_src_tag);
                check_bit("src_ready", src_ready, cur.e_src_rdy);
            end
            if (cur.valid && cur.has_dest && cur.e_ready) begin
                check_tag("new_tag", new_tag, cur.e_new);
                check_tag("old_tag", old_tag, cur.e_old);
            end
            check_bid("assigned_b_id", assigned_b_id, cur.e_bid);
            check_bit("recover_valid", recover_valid, cur.e_rec);
            if (cur.e_rec) begin
                check_pc("recover_pc", recover_pc, cur.e_rec_pc);
            end
            @(negedge clock);
        end

        $display("sim passed");
        $finish;
    end

endmodule

//--- dv/clock_gen.sv
module clock_gen #(
    parameter int period = 40
) (
    output logic clock
);

    initial begin
        clock = 1'b0;
    end

    always #(period / 2) clock = ~clock;

endmodule

//--- src/rename_unit.sv
module rename_unit import rename_pkg::*; import branch_pkg::*; #(
    parameter int depth = BR_DEPTH
) (
    input  logic             clock,
    input  logic             reset,
    input  logic             dispatch_valid,
    input  logic [31:0]      dispatch_pc,
    input  logic             has_dest,
    input  arch_idx_t        dest_arch,
    input  arch_idx_t        src_arch,
    input  logic             is_branch,
    output logic             dispatch_ready,
    output phys_tag_t        src_tag,
    output logic             src_ready,
    output phys_tag_t        new_tag,
    output phys_tag_t        old_tag,
    output logic [depth-1:0] assigned_b_id,
    input  logic             cdb_valid,
    input  phys_tag_t        cdb_tag,
    input  logic             retire_valid,
    input  phys_tag_t        retire_tag,
    input  br_task_t         br_task,
    input  logic [depth-1:0] rem_b_id,
    output logic             recover_valid,
    output logic [31:0]      recover_pc
);

    logic        take;
    logic        alloc;
    logic        restore;
    logic        stack_full;
    logic        fl_empty;
    map_array_t  restore_map;
    fl_ptr_t     restore_head;
    map_array_t  map_live;
    fl_ptr_t     fl_head;
    checkpoint_t cp;
    map_entry_t  src_entry;

    assign src_tag   = src_entry.tag;
    assign src_ready = src_entry.ready;

    rename_ctrl #(
        .depth(depth)
    ) u_ctrl (
        .clock         (clock),
        .reset         (reset),
        .dispatch_valid(dispatch_valid),
        .is_branch     (is_branch),
        .has_dest      (has_dest),
        .br_task       (br_task),
        .stack_full    (stack_full),
        .fl_empty      (fl_empty),
        .cp_in         (cp),
        .dispatch_ready(dispatch_ready),
        .take          (take),
        .alloc         (alloc),
        .restore       (restore),
        .restore_map   (restore_map),
        .restore_head  (restore_head),
        .recover_valid (recover_valid),
        .recover_pc    (recover_pc)
    );

    br_stack #(
        .depth(depth)
    ) u_stack (
        .clock        (clock),
        .reset        (reset),
        .take         (take),
        .pc           (dispatch_pc),
        .in_mt        (map_live),
        .in_fl_head   (fl_head),
        .cdb_valid    (cdb_valid),
        .cdb_tag      (cdb_tag),
        .br_task      (br_task),
        .rem_b_id     (rem_b_id),
        .assigned_b_id(assigned_b_id),
        .cp_out       (cp),
        .full         (stack_full)
    );

    map_table u_map (
        .clock      (clock),
        .reset      (reset),
        .write_en   (alloc),
        .write_arch (dest_arch),
        .write_tag  (new_tag),
        .read_arch  (src_arch),
        .read_entry (src_entry),
        .old_tag    (old_tag),
        .cdb_valid  (cdb_valid),
        .cdb_tag    (cdb_tag),
        .restore    (restore),
        .restore_map(restore_map),
        .map_out    (map_live)
    );

    free_list u_free (
        .clock       (clock),
        .reset       (reset),
        .pop         (alloc),
        .push        (retire_valid),
        .push_tag    (retire_tag),
        .head_tag    (new_tag),
        .head        (fl_head),
        .empty       (fl_empty),
        .restore     (restore),
        .restore_head(restore_head)
    );

endmodule

//--- src/rename_ctrl.sv
module rename_ctrl import rename_pkg::*; import branch_pkg::*; #(
    parameter int depth = BR_DEPTH
) (
    input  logic        clock,
    input  logic        reset,
    input  logic        dispatch_valid,
    input  logic        is_branch,
    input  logic        has_dest,
    input  br_task_t    br_task,
    input  logic        stack_full,
    input  logic        fl_empty,
    input  checkpoint_t cp_in,
    output logic        dispatch_ready,
    output logic        take,
    output logic        alloc,
    output logic        restore,
    output map_array_t  restore_map,
    output fl_ptr_t     restore_head,
    output logic        recover_valid,
    output logic [31:0] recover_pc
);

    typedef enum logic {
        RUN     = 1'b0,
        RECOVER = 1'b1
    } state_t;

    state_t      state;
    map_array_t  rec_mt_q;
    fl_ptr_t     fl_head_q;
    logic [31:0] rec_pc_q;

    assign dispatch_ready = (state == RUN) && (br_task == NONE)
                          && !(stack_full && is_branch) && !(fl_empty && has_dest);

    assign take  = dispatch_valid && dispatch_ready && is_branch;
    assign alloc = dispatch_valid && dispatch_ready && has_dest;

    // one recovery cycle, the load lands at its closing edge
    assign restore       = (state == RECOVER);
    assign recover_valid = (state == RECOVER);
    assign restore_map   = rec_mt_q;
    assign restore_head  = fl_head_q;
    assign recover_pc    = rec_pc_q;

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= RUN;
        end else begin
            state <= (br_task == SQUASH) ? RECOVER : RUN;
        end
    end

    always_ff @(posedge clock) begin
        if (br_task == SQUASH) begin
            rec_mt_q  <= cp_in.rec_mt;
            fl_head_q <= cp_in.fl_head;
            rec_pc_q  <= cp_in.rec_pc;
        end
    end

    // the stack must find a live checkpoint for the squashed id
    a_squash_hit: assert property (@(posedge clock) disable iff (reset)
        br_task == SQUASH |-> cp_in.valid && cp_in.b_id[depth-1:0] != '0);

endmodule

//--- src/br_stack.sv
module br_stack import rename_pkg::*; import branch_pkg::*; #(
    parameter int depth = BR_DEPTH
) (
    input  logic             clock,
    input  logic             reset,
    input  logic             take,
    input  logic [31:0]      pc,
    input  map_array_t       in_mt,
    input  fl_ptr_t          in_fl_head,
    input  logic             cdb_valid,
    input  phys_tag_t        cdb_tag,
    input  br_task_t         br_task,
    input  logic [depth-1:0] rem_b_id,
    output logic [depth-1:0] assigned_b_id,
    output checkpoint_t      cp_out,
    output logic             full
);

    // the checkpoint fields are BR_DEPTH wide
    if (depth > BR_DEPTH) begin : g_depth_check
        $error("br_stack depth exceeds BR_DEPTH");
    end

    checkpoint_t [depth-1:0] entries;
    checkpoint_t [depth-1:0] next_entries;
    logic        [depth-1:0] live;
    logic        [depth-1:0] slot_gnt;

    // slot i always carries id bit i
    always_comb begin
        for (int i = 0; i < depth; i++) begin
            live[i] = entries[i].valid;
        end
    end

    psel_gen #(
        .width(depth)
    ) u_slot_sel (
        .req  (~live),
        .gnt  (slot_gnt),
        .empty(full)
    );

    assign assigned_b_id = take ? slot_gnt : '0;

    always_comb begin
        next_entries = entries;
        cp_out       = '0;

        case (br_task)
            SQUASH: begin
                for (int i = 0; i < depth; i++) begin
                    if (entries[i].valid && entries[i].b_id[depth-1:0] == rem_b_id) begin
                        cp_out        = entries[i];
                        // include this cycle's broadcast in the restored map
                        cp_out.rec_mt = cdb_refresh(entries[i].rec_mt, cdb_valid, cdb_tag);
                        next_entries[i].valid = 1'b0;
                    end
                    // younger branches die with it
                    if ((entries[i].b_mask[depth-1:0] & rem_b_id) != '0) begin
                        next_entries[i].valid = 1'b0;
                    end
                end
            end
            CLEAR: begin
                for (int i = 0; i < depth; i++) begin
                    if (entries[i].b_id[depth-1:0] == rem_b_id) begin
                        next_entries[i].valid = 1'b0;
                    end
                    next_entries[i].b_mask = entries[i].b_mask & ~(BR_DEPTH'(rem_b_id));
                end
            end
            default: begin
                if (take) begin
                    for (int i = 0; i < depth; i++) begin
                        if (slot_gnt[i]) begin
                            next_entries[i].valid   = 1'b1;
                            next_entries[i].b_id    = BR_DEPTH'(slot_gnt);
                            next_entries[i].b_mask  = BR_DEPTH'(live);
                            next_entries[i].rec_pc  = pc;
                            next_entries[i].rec_mt  = in_mt;
                            next_entries[i].fl_head = in_fl_head;
                        end
                    end
                end
            end
        endcase

        // covers the entry taken this cycle as well
        for (int i = 0; i < depth; i++) begin
            next_entries[i].rec_mt = cdb_refresh(next_entries[i].rec_mt, cdb_valid, cdb_tag);
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < depth; i++) begin
                entries[i].valid <= 1'b0;
            end
        end else begin
            entries <= next_entries;
        end
    end

    // a resolved branch must name exactly one live checkpoint
    a_rem_live: assert property (@(posedge clock) disable iff (reset)
        br_task != NONE |-> $onehot(rem_b_id) && (rem_b_id & live) != '0);

    a_take_not_full: assert property (@(posedge clock) disable iff (reset)
        take |-> !full);

endmodule

//--- src/map_table.sv
module map_table import rename_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  logic       write_en,
    input  arch_idx_t  write_arch,
    input  phys_tag_t  write_tag,
    input  arch_idx_t  read_arch,
    output map_entry_t read_entry,
    output phys_tag_t  old_tag,
    input  logic       cdb_valid,
    input  phys_tag_t  cdb_tag,
    input  logic       restore,
    input  map_array_t restore_map,
    output map_array_t map_out
);

    map_array_t map_q;
    map_array_t wr_map;
    map_array_t next_map;

    // lookups see the map from before this instruction's write
    assign read_entry = map_q[read_arch];
    assign old_tag    = map_q[write_arch].tag;

    always_comb begin
        wr_map = map_q;
        if (write_en) begin
            wr_map[write_arch].tag   = write_tag;
            wr_map[write_arch].ready = 1'b0;
        end
    end

    // the map as it stands after this instruction, for checkpoints
    assign map_out = wr_map;

    always_comb begin
        next_map = restore ? restore_map : wr_map;
        next_map = cdb_refresh(next_map, cdb_valid, cdb_tag);
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            // identity map, all values present
            for (int i = 0; i < ARCH_REGS; i++) begin
                map_q[i].tag   <= phys_tag_t'(i);
                map_q[i].ready <= 1'b1;
            end
        end else begin
            map_q <= next_map;
        end
    end

endmodule

//--- src/free_list.sv
module free_list import rename_pkg::*; (
    input  logic      clock,
    input  logic      reset,
    input  logic      pop,
    input  logic      push,
    input  phys_tag_t push_tag,
    output phys_tag_t head_tag,
    output fl_ptr_t   head,
    output logic      empty,
    input  logic      restore,
    input  fl_ptr_t   restore_head
);

    localparam int FL_SIZE = PHYS_REGS - ARCH_REGS;
    localparam int IDX_W   = $clog2(FL_SIZE);

    phys_tag_t tags [FL_SIZE];
    fl_ptr_t   head_q;
    fl_ptr_t   tail_q;
    fl_ptr_t   count;

    assign count    = tail_q - head_q;
    assign empty    = (count == '0);
    assign head_tag = tags[head_q[IDX_W-1:0]];

    // head after this cycle's pop, which is what a checkpoint keeps
    assign head = head_q + fl_ptr_t'(pop);

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < FL_SIZE; i++) begin
                tags[i] <= phys_tag_t'(ARCH_REGS + i);
            end
            head_q <= '0;
            tail_q <= fl_ptr_t'(FL_SIZE);
        end else begin
            if (push) begin
                tags[tail_q[IDX_W-1:0]] <= push_tag;
                tail_q <= tail_q + 1'b1;
            end
            // tail is left alone on recovery
            if (restore) begin
                head_q <= restore_head;
            end else if (pop) begin
                head_q <= head_q + 1'b1;
            end
        end
    end

    a_no_pop_empty: assert property (@(posedge clock) disable iff (reset)
        pop |-> !empty);

    a_no_push_full: assert property (@(posedge clock) disable iff (reset)
        push |-> count != fl_ptr_t'(FL_SIZE));

endmodule

//--- src/psel_gen.sv
module psel_gen #(
    parameter int width = 4
) (
    input  logic [width-1:0] req,
    output logic [width-1:0] gnt,
    output logic             empty
);

    logic found;

    // lowest request wins
    always_comb begin
        gnt   = '0;
        found = 1'b0;
        for (int i = 0; i < width; i++) begin
            if (req[i] && !found) begin
                gnt[i] = 1'b1;
                found  = 1'b1;
            end
        end
    end

    assign empty = ~|req;

endmodule

//--- src/branch_pkg.sv
package branch_pkg;

    localparam int BR_DEPTH = 4;

    // command from the branch unit
    typedef enum logic [1:0] {
        NONE   = 2'd0,
        CLEAR  = 2'd1,
        SQUASH = 2'd2
    } br_task_t;

    // b_id is one-hot, b_mask holds the ids of older live branches
    typedef struct packed {
        logic                   valid;
        logic [BR_DEPTH-1:0]    b_id;
        logic [BR_DEPTH-1:0]    b_mask;
        logic [31:0]            rec_pc;
        rename_pkg::map_array_t rec_mt;
        rename_pkg::fl_ptr_t    fl_head;
    } checkpoint_t;

endpackage

//--- src/rename_pkg.sv
package rename_pkg;

    localparam int ARCH_REGS = 32;
    localparam int PHYS_REGS = 64;

    typedef logic [$clog2(ARCH_REGS)-1:0] arch_idx_t;
    typedef logic [$clog2(PHYS_REGS)-1:0] phys_tag_t;

    // extra msb tells a full queue from an empty one
    typedef logic [$clog2(PHYS_REGS):0] fl_ptr_t;

    typedef struct packed {
        phys_tag_t tag;
        logic      ready;
    } map_entry_t;

    typedef map_entry_t [ARCH_REGS-1:0] map_array_t;

    // completion broadcast marks every mapping of the tag as ready
    function automatic map_array_t cdb_refresh(map_array_t map, logic valid, phys_tag_t tag);
        map_array_t result;
        result = map;
        for (int a = 0; a < ARCH_REGS; a++) begin
            if (valid && result[a].tag == tag) begin
                result[a].ready = 1'b1;
            end
        end
        return result;
    endfunction

endpackage
